// ==== rtl/issuePkg.sv ====
package issuePkg;

    // ----------------------------------------------------------------------
    // widths
    // ----------------------------------------------------------------------
    typedef logic [31:0] instWord_t;
    typedef logic [4:0]  regNum_t;
    typedef logic [5:0]  opField_t;   // opcode and funct fields
    typedef logic [1:0]  slotMask_t;  // bit i set: may go in slot i

    typedef enum logic [1:0] {
        ISSUE_NONE   = 2'd0,
        ISSUE_SINGLE = 2'd1,
        ISSUE_DUAL   = 2'd2
    } issueMode_t;

    localparam slotMask_t SLOT_ZERO = 2'b01;
    localparam slotMask_t SLOT_ONE  = 2'b10;
    localparam slotMask_t SLOT_BOTH = 2'b11;

    // ----------------------------------------------------------------------
    // opcode subset
    // ----------------------------------------------------------------------
    localparam opField_t OP_SPECIAL     = 6'd0;
    localparam opField_t OP_REGIMM      = 6'd1;
    localparam opField_t OP_J           = 6'd2;
    localparam opField_t OP_JAL         = 6'd3;
    localparam opField_t OP_BEQ         = 6'd4;
    localparam opField_t OP_BNE         = 6'd5;
    localparam opField_t OP_ALUI_FIRST  = 6'd8;   // addi .. lui
    localparam opField_t OP_ALUI_LAST   = 6'd15;
    localparam opField_t OP_LUI         = 6'd15;
    localparam opField_t OP_LOAD_FIRST  = 6'd32;
    localparam opField_t OP_LOAD_LAST   = 6'd37;
    localparam opField_t OP_STORE_FIRST = 6'd40;
    localparam opField_t OP_STORE_LAST  = 6'd43;

    localparam opField_t FN_JR           = 6'd8;
    localparam opField_t FN_MULDIV_FIRST = 6'd24;  // mult, multu, div, divu
    localparam opField_t FN_MULDIV_LAST  = 6'd27;

    localparam regNum_t LINK_REG = 5'd31;

    localparam int WINDOW_DEPTH_DEF = 4;

endpackage

// ==== rtl/issueIfs.sv ====
`timescale 1ns/1ps

// two oldest window entries and the pop request coming back
interface windowIf;
    import issuePkg::*;

    instWord_t [1:0] headInst;
    logic      [1:0] headValid;  // bit 1 only with bit 0
    logic      [1:0] popCount;   // 0, 1 or 2

    modport window (output headInst, output headValid, input popCount);
    modport arbiter (input headInst, input headValid, output popCount);
endinterface

// decode result of one slot
interface slotInfoIf;
    import issuePkg::*;

    regNum_t   rsNum;
    regNum_t   rtNum;
    logic      needRs;
    logic      needRt;
    regNum_t   writeNum;  // zero means no write
    slotMask_t slotMask;

    modport decoder (
        output rsNum, output rtNum, output needRs, output needRt,
        output writeNum, output slotMask
    );
    modport arbiter (
        input rsNum, input rtNum, input needRs, input needRt,
        input writeNum, input slotMask
    );
endinterface

// ==== rtl/instWindow.sv ====
`timescale 1ns/1ps

module instWindow #(
    parameter int WindowDepth = issuePkg::WINDOW_DEPTH_DEF
) (
    input  logic                clk_i,
    input  logic                arstN_i,
    input  logic                inValid_i,
    output logic                inReady_o,
    input  issuePkg::instWord_t inInst_i,
    windowIf.window             win
);
    import issuePkg::*;

    localparam int PtrW = $clog2(WindowDepth);
    localparam int CntW = PtrW + 1;

    instWord_t       mem [WindowDepth];
    logic [PtrW-1:0] rdPtr_q;
    logic [PtrW-1:0] wrPtr_q;
    logic [CntW-1:0] count_q;
    logic            holdSingle_q;
    logic            full;
    logic            push;

    assign full      = count_q == CntW'(WindowDepth);
    assign inReady_o = !full || (win.popCount != 2'd0);  // full slot freed by a pop
    assign push      = inValid_i && inReady_o;

    // ----------------------------------------------------------------------
    // head view
    // ----------------------------------------------------------------------
    assign win.headInst[0]  = mem[rdPtr_q];
    assign win.headInst[1]  = mem[rdPtr_q + PtrW'(1)];
    assign win.headValid[0] = count_q != '0;
    // a single issue that is waiting keeps its pair, even when a second word lands
    assign win.headValid[1] = (count_q > CntW'(1)) && !holdSingle_q;

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wrPtr_q] <= inInst_i;
        end
    end

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            rdPtr_q      <= '0;
            wrPtr_q      <= '0;
            count_q      <= '0;
            holdSingle_q <= 1'b0;
        end else begin
            if (push) begin
                wrPtr_q <= wrPtr_q + PtrW'(1);
            end
            rdPtr_q      <= rdPtr_q + PtrW'(win.popCount);
            count_q      <= count_q + CntW'(push) - CntW'(win.popCount);
            holdSingle_q <= win.headValid[0] && !win.headValid[1] && (win.popCount == 2'd0);
        end
    end

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------
    // occupancy never runs past the depth
    countWithinDepth : assert property (@(posedge clk_i) disable iff (!arstN_i)
        count_q <= CntW'(WindowDepth));

    // arbiter side must not pop what is not there
    popWithinCount : assert property (@(posedge clk_i) disable iff (!arstN_i)
        CntW'(win.popCount) <= count_q);

endmodule

// ==== rtl/slotDecoder.sv ====
`timescale 1ns/1ps

module slotDecoder (
    input  issuePkg::instWord_t inst_i,
    slotInfoIf.decoder          info
);
    import issuePkg::*;

    opField_t  opcode;
    opField_t  funct;
    regNum_t   rs;
    regNum_t   rt;
    regNum_t   rd;
    logic      needRs;
    logic      needRt;
    logic      isMulDiv;
    regNum_t   writeReg;
    slotMask_t mask;

    assign opcode   = inst_i[31:26];
    assign rs       = inst_i[25:21];
    assign rt       = inst_i[20:16];
    assign rd       = inst_i[15:11];
    assign funct    = inst_i[5:0];
    assign isMulDiv = funct inside {[FN_MULDIV_FIRST:FN_MULDIV_LAST]};

    always_comb begin
        needRs   = 1'b0;
        needRt   = 1'b0;
        writeReg = '0;
        mask     = SLOT_ZERO;  // unknown opcodes stay in slot 0
        case (opcode) inside
            OP_SPECIAL: begin
                needRs = 1'b1;
                needRt = funct != FN_JR;
                if (funct != FN_JR && !isMulDiv) begin
                    writeReg = rd;
                    mask     = SLOT_BOTH;
                end
            end
            OP_REGIMM:  needRs = 1'b1;
            OP_J:       mask = SLOT_ZERO;
            OP_JAL:     writeReg = LINK_REG;
            OP_BEQ, OP_BNE: begin
                needRs = 1'b1;
                needRt = 1'b1;
            end
            [OP_ALUI_FIRST:OP_ALUI_LAST]: begin
                needRs   = opcode != OP_LUI;  // lui has no source
                writeReg = rt;
                mask     = SLOT_BOTH;
            end
            [OP_LOAD_FIRST:OP_LOAD_LAST]: begin
                needRs   = 1'b1;
                writeReg = rt;
                mask     = SLOT_ONE;
            end
            [OP_STORE_FIRST:OP_STORE_LAST]: begin
                needRs = 1'b1;
                needRt = 1'b1;
                mask   = SLOT_ONE;
            end
            default: mask = SLOT_ZERO;
        endcase
    end

    // unused sources read as r0, a write to r0 already reads as none
    assign info.rsNum    = needRs ? rs : '0;
    assign info.rtNum    = needRt ? rt : '0;
    assign info.needRs   = needRs;
    assign info.needRt   = needRt;
    assign info.writeNum = writeReg;
    assign info.slotMask = mask;

endmodule

// ==== rtl/issueArbiter.sv ====
`timescale 1ns/1ps

module issueArbiter (
    windowIf.arbiter                  win,
    slotInfoIf.arbiter                slot [2],
    output logic                      issueValid_o,
    input  logic                      issueReady_i,
    output issuePkg::issueMode_t      issueMode_o,
    output issuePkg::instWord_t [1:0] laneInst_o,
    output issuePkg::regNum_t   [1:0] laneRs_o,
    output issuePkg::regNum_t   [1:0] laneRt_o,
    output logic [1:0][1:0]           laneNeedRead_o,  // per lane {needRt, needRs}
    output issuePkg::regNum_t   [1:0] laneWrite_o
);
    import issuePkg::*;

    logic slotFit;
    logic rawHazard;
    logic dualPick;
    logic taken;

    // ----------------------------------------------------------------------
    // hazard checks
    // ----------------------------------------------------------------------
    assign slotFit = slot[0].slotMask[0] && slot[1].slotMask[1];

    // second instruction reads what the first one writes
    assign rawHazard = (slot[0].writeNum != '0) &&
                       ((slot[1].needRs && slot[1].rsNum == slot[0].writeNum) ||
                        (slot[1].needRt && slot[1].rtNum == slot[0].writeNum));

    always_comb begin
        issueValid_o = win.headValid[0];
        if (!win.headValid[0]) begin
            issueMode_o = ISSUE_NONE;
        end else if (win.headValid[1] && slotFit && !rawHazard) begin
            issueMode_o = ISSUE_DUAL;
        end else begin
            issueMode_o = ISSUE_SINGLE;
        end
        // second head never valid without the first
        assert (win.headValid[0] || !win.headValid[1]);
    end

    assign dualPick     = issueMode_o == ISSUE_DUAL;
    assign taken        = issueValid_o && issueReady_i;
    assign win.popCount = taken ? (dualPick ? 2'd2 : 2'd1) : 2'd0;

    // ----------------------------------------------------------------------
    // lane steering
    // ----------------------------------------------------------------------
    // lane 1 mirrors lane 0 on single issue
    assign laneInst_o[0]     = win.headInst[0];
    assign laneRs_o[0]       = slot[0].rsNum;
    assign laneRt_o[0]       = slot[0].rtNum;
    assign laneNeedRead_o[0] = {slot[0].needRt, slot[0].needRs};
    assign laneWrite_o[0]    = slot[0].writeNum;

    assign laneInst_o[1]     = dualPick ? win.headInst[1] : win.headInst[0];
    assign laneRs_o[1]       = dualPick ? slot[1].rsNum : slot[0].rsNum;
    assign laneRt_o[1]       = dualPick ? slot[1].rtNum : slot[0].rtNum;
    assign laneNeedRead_o[1] = dualPick ? {slot[1].needRt, slot[1].needRs}
                                        : {slot[0].needRt, slot[0].needRs};
    assign laneWrite_o[1]    = dualPick ? slot[1].writeNum : slot[0].writeNum;

endmodule

// ==== rtl/dualIssueTop.sv ====
`timescale 1ns/1ps

module dualIssueTop #(
    parameter int WindowDepth = issuePkg::WINDOW_DEPTH_DEF
) (
    input  logic                      clk_i,
    input  logic                      arstN_i,
    input  logic                      inValid_i,
    output logic                      inReady_o,
    input  issuePkg::instWord_t       inInst_i,
    output logic                      issueValid_o,
    input  logic                      issueReady_i,
    output issuePkg::issueMode_t      issueMode_o,
    output issuePkg::instWord_t [1:0] laneInst_o,
    output issuePkg::regNum_t   [1:0] laneRs_o,
    output issuePkg::regNum_t   [1:0] laneRt_o,
    output logic [1:0][1:0]           laneNeedRead_o,
    output issuePkg::regNum_t   [1:0] laneWrite_o
);

    windowIf   winBus ();
    slotInfoIf slotBus [2] ();

    instWindow #(
        .WindowDepth(WindowDepth)
    ) uWindow (
        .clk_i    (clk_i),
        .arstN_i  (arstN_i),
        .inValid_i(inValid_i),
        .inReady_o(inReady_o),
        .inInst_i (inInst_i),
        .win      (winBus)
    );

    // one decoder per head entry
    generate
        for (genvar g = 0; g < 2; g++) begin : gSlot
            slotDecoder uDecoder (
                .inst_i(winBus.headInst[g]),
                .info  (slotBus[g])
            );
        end
    endgenerate

    issueArbiter uArbiter (
        .win           (winBus),
        .slot          (slotBus),
        .issueValid_o  (issueValid_o),
        .issueReady_i  (issueReady_i),
        .issueMode_o   (issueMode_o),
        .laneInst_o    (laneInst_o),
        .laneRs_o      (laneRs_o),
        .laneRt_o      (laneRt_o),
        .laneNeedRead_o(laneNeedRead_o),
        .laneWrite_o   (laneWrite_o)
    );

endmodule

// ==== verif/tbChecks.svh ====
// expected decode of one word, packed as {slotMask, needRt, needRs, rs, rt, write}
function automatic logic [18:0] expDecode(input instWord_t w);
    opField_t  op;
    opField_t  fn;
    logic      useRs;
    logic      useRt;
    regNum_t   wr;
    slotMask_t slots;
    op    = w[31:26];
    fn    = w[5:0];
    useRs = 1'b1;  // most classes read rs
    useRt = 1'b0;
    wr    = '0;
    slots = 2'b01;
    if (op == OP_SPECIAL) begin
        useRt = fn != FN_JR;
        if (fn != FN_JR && (fn < FN_MULDIV_FIRST || fn > FN_MULDIV_LAST)) begin
            wr    = w[15:11];
            slots = 2'b11;
        end
    end else if (op == OP_J || op == OP_JAL) begin
        useRs = 1'b0;
        wr    = op == OP_JAL ? LINK_REG : 5'd0;
    end else if (op == OP_BEQ || op == OP_BNE) begin
        useRt = 1'b1;
    end else if (op >= OP_ALUI_FIRST && op <= OP_ALUI_LAST) begin
        useRs = op != OP_LUI;
        wr    = w[20:16];
        slots = 2'b11;
    end else if (op >= OP_LOAD_FIRST && op <= OP_LOAD_LAST) begin
        wr    = w[20:16];
        slots = 2'b10;
    end else if (op >= OP_STORE_FIRST && op <= OP_STORE_LAST) begin
        useRt = 1'b1;
        slots = 2'b10;
    end else if (op != OP_REGIMM) begin
        useRs = 1'b0;  // unknown opcode
    end
    return {slots, useRt, useRs, useRs ? w[25:21] : 5'd0, useRt ? w[20:16] : 5'd0, wr};
endfunction

function automatic issueMode_t expectMode(input int qs, input logic held,
                                          input instWord_t w0, input instWord_t w1);
    logic [18:0] d0;
    logic [18:0] d1;
    logic        raw;
    d0  = expDecode(w0);
    d1  = expDecode(w1);
    // second word reads what the first one writes
    raw = d0[4:0] != 5'd0 && ((d1[15] && d1[14:10] == d0[4:0]) ||
                              (d1[16] && d1[9:5] == d0[4:0]));
    if (qs == 0) begin
        return ISSUE_NONE;
    end else if (qs > 1 && !held && d0[17] && d1[18] && !raw) begin
        return ISSUE_DUAL;
    end
    return ISSUE_SINGLE;
endfunction

task automatic checkLane(input int lane, input instWord_t w);
    logic [18:0] want;
    logic [16:0] got;
    want = expDecode(w);
    got  = {laneNeedRead_o[lane], laneRs_o[lane], laneRt_o[lane], laneWrite_o[lane]};
    assert (laneInst_o[lane] == w) else begin
        orderErrs++;
        $display("error %0t: lane %0d carries %h, expected %h", $time, lane, laneInst_o[lane], w);
    end
    assert (got == want[16:0]) else begin
        decodeErrs++;
        $display("error %0t: lane %0d decode %h for word %h, expected %h",
                 $time, lane, got, w, want[16:0]);
    end
endtask

// one monitor step at the falling edge, inputs and outputs are settled here
task automatic checkCycle();
    int          qs;
    logic        taken;
    instWord_t   w0;
    instWord_t   w1;
    issueMode_t  mode;
    logic [99:0] payload;
    qs      = sentQ.size();
    taken   = issueValid_o && issueReady_i;
    w0      = qs > 0 ? sentQ[0] : '0;
    w1      = qs > 1 ? sentQ[1] : '0;
    mode    = expectMode(qs, holdModel, w0, w1);
    payload = {issueMode_o, laneInst_o, laneRs_o, laneRt_o, laneNeedRead_o, laneWrite_o};
    assert (issueValid_o == (qs != 0) && inReady_o == (qs < WindowDepth || taken)) else begin
        protocolErrs++;
        $display("error %0t: issueValid_o %b inReady_o %b with %0d words waiting",
                 $time, issueValid_o, inReady_o, qs);
    end
    assert (!prevHeld || payload == prevPayload) else begin
        protocolErrs++;
        $display("error %0t: payload changed while the issue was stalled", $time);
    end
    if (taken && qs != 0) begin
        assert (issueMode_o == mode) else begin
            modeErrs++;
            $display("error %0t: mode %s, expected %s", $time, issueMode_o.name(), mode.name());
        end
        checkLane(0, w0);
        checkLane(1, mode == ISSUE_DUAL ? w1 : w0);
        void'(sentQ.pop_front());
        if (mode == ISSUE_DUAL) begin
            void'(sentQ.pop_front());
            numDual++;
        end else begin
            numSingle++;
        end
    end
    // a presented single stays single until taken
    holdModel   = qs != 0 && !(qs > 1 && !holdModel) && !taken;
    prevHeld    = issueValid_o && !issueReady_i;
    prevPayload = payload;
    if (inValid_i && inReady_o) begin
        sentQ.push_back(inInst_i);
    end
endtask

// ==== verif/tbDualIssue.sv ====
`timescale 1ns/1ps

module tbDualIssue;
    import issuePkg::*;

    localparam int WindowDepth = WINDOW_DEPTH_DEF;
    localparam int NumRandom   = 200;
    localparam int TotalWords  = 6 * 3 + WindowDepth + 2 + NumRandom;

    logic            clk_i = 1'b0;
    logic            arstN_i;
    logic            inValid_i;
    logic            inReady_o;
    instWord_t       inInst_i;
    logic            issueValid_o;
    logic            issueReady_i;
    issueMode_t      issueMode_o;
    instWord_t [1:0] laneInst_o;
    regNum_t   [1:0] laneRs_o;
    regNum_t   [1:0] laneRt_o;
    logic [1:0][1:0] laneNeedRead_o;
    regNum_t   [1:0] laneWrite_o;

    // reference model, words accepted but not yet issued
    instWord_t   sentQ[$];
    logic        holdModel = 1'b0;
    logic        prevHeld = 1'b0;
    logic [99:0] prevPayload = '0;
    int          readyMode = 0;  // 0 low, 1 high, 2 random
    int          orderErrs = 0;
    int          decodeErrs = 0;
    int          modeErrs = 0;
    int          protocolErrs = 0;
    int          numSingle = 0;
    int          numDual = 0;

    dualIssueTop #(.WindowDepth(WindowDepth)) DUT (.*);

    `include "tbChecks.svh"

    always #50 clk_i = ~clk_i;

    always @(negedge clk_i) begin
        if (arstN_i) begin
            checkCycle();
        end
    end

    initial begin
        issueReady_i = 1'b0;
        forever begin
            @(posedge clk_i);
            #1;
            issueReady_i = readyMode == 2 ? ($urandom_range(0, 2) != 0) : readyMode == 1;
        end
    end

    initial begin
        repeat (TotalWords * 20) @(posedge clk_i);
        $display("timeout: issue stage stalled for %0d cycles", TotalWords * 20);
        $display(">>> FAIL");
        $finish;
    end

    function automatic instWord_t randomInst();
        opField_t op;
        opField_t fn;
        op = OP_SPECIAL;
        fn = 6'd32 + 6'($urandom_range(0, 11));  // alu functs
        case ($urandom_range(0, 9))
            0: fn = FN_JR;
            1: fn = FN_MULDIV_FIRST + 6'($urandom_range(0, 3));
            2: op = OP_REGIMM + 6'($urandom_range(0, 2));  // regimm, j, jal
            3: op = OP_BEQ + 6'($urandom_range(0, 1));
            4, 5: op = OP_ALUI_FIRST + 6'($urandom_range(0, 7));
            6: op = OP_LOAD_FIRST + 6'($urandom_range(0, 5));
            7: op = OP_STORE_FIRST + 6'($urandom_range(0, 3));
            8: op = 6'd16 + 6'($urandom_range(0, 3));  // outside the subset
            default: ;
        endcase
        // registers kept below 8 so hazards show up often
        return {op, 2'b00, 3'($urandom_range(0, 7)), 2'b00, 3'($urandom_range(0, 7)),
                2'b00, 3'($urandom_range(0, 7)), 5'd0, fn};
    endfunction

    task automatic sendWord(input instWord_t w, input logic randomValid);
        logic done;
        done     = 1'b0;
        inInst_i = w;
        while (!done) begin
            inValid_i = randomValid ? ($urandom_range(0, 3) != 0) : 1'b1;
            @(negedge clk_i);
            done = inValid_i && inReady_o;
            @(posedge clk_i);
            #1;
        end
        inValid_i = 1'b0;
    endtask

    task automatic drainWindow();
        readyMode = 1;
        while (sentQ.size() != 0) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    // filler goes out single first, then the pair sits at the head together
    task automatic runPair(input instWord_t first, input instWord_t second);
        readyMode = 0;
        @(posedge clk_i);
        #1;
        sendWord({OP_ALUI_FIRST + 6'd5, 5'd0, 5'd1, 16'h00ff}, 1'b0);
        sendWord(first, 1'b0);
        sendWord(second, 1'b0);
        drainWindow();
    endtask

    initial begin
        void'($urandom(32'ha436c888));
        arstN_i   = 1'b0;
        inValid_i = 1'b0;
        inInst_i  = '0;
        repeat (2) @(posedge clk_i);
        #1;
        arstN_i = 1'b1;
        @(posedge clk_i);
        #1;

        // ---------------------------------------------------------------------
        // directed pairs
        // ---------------------------------------------------------------------
        runPair({OP_ALUI_FIRST, 5'd2, 5'd5, 16'h0004},
                {OP_SPECIAL, 5'd5, 5'd6, 5'd7, 5'd0, 6'd32});   // raw on rs
        runPair({OP_ALUI_FIRST, 5'd2, 5'd0, 16'h0004},
                {OP_SPECIAL, 5'd0, 5'd6, 5'd7, 5'd0, 6'd32});   // r0 write, no hazard
        runPair({OP_SPECIAL, 5'd2, 5'd3, 5'd9, 5'd0, 6'd32},
                {OP_STORE_LAST, 5'd4, 5'd9, 16'h0000});         // raw on rt
        runPair({OP_LOAD_FIRST + 6'd3, 5'd2, 5'd3, 16'h0008},
                {OP_SPECIAL, 5'd4, 5'd6, 5'd7, 5'd0, 6'd32});   // load first
        runPair({OP_SPECIAL, 5'd2, 5'd3, 5'd4, 5'd0, 6'd33},
                {OP_BEQ, 5'd5, 5'd6, 16'h0010});                // branch second
        runPair({OP_SPECIAL, 5'd2, 5'd3, 5'd4, 5'd0, 6'd33},
                {OP_LOAD_FIRST + 6'd3, 5'd5, 5'd6, 16'h0000});  // dual

        // back-pressure, two words more than the window holds
        readyMode = 0;
        @(posedge clk_i);
        #1;
        fork
            repeat (WindowDepth + 2) sendWord(randomInst(), 1'b0);
            begin
                repeat (WindowDepth + 4) @(posedge clk_i);
                readyMode = 1;
            end
        join
        drainWindow();

        // ---------------------------------------------------------------------
        // random traffic
        // ---------------------------------------------------------------------
        readyMode = 2;
        repeat (NumRandom) sendWord(randomInst(), 1'b1);
        drainWindow();
        repeat (2) @(posedge clk_i);

        $display("done: %0d single, %0d dual, errors order %0d decode %0d mode %0d protocol %0d",
                 numSingle, numDual, orderErrs, decodeErrs, modeErrs, protocolErrs);
        if (orderErrs + decodeErrs + modeErrs + protocolErrs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+verif
rtl/issuePkg.sv
rtl/issueIfs.sv
rtl/instWindow.sv
rtl/slotDecoder.sv
rtl/issueArbiter.sv
rtl/dualIssueTop.sv
verif/tbDualIssue.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, pass only on the pass line
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --top-module tbDualIssue -f sources.f -o simDualIssue; then
    echo "verilator build failed"
    exit 1
fi

if ! out=$(./obj_dir/simDualIssue); then
    printf '%s\n' "$out"
    echo "simulation exited with an error"
    exit 1
fi
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
    exit 0
fi
exit 1
